// File: Makefile
VERILATOR = verilator
VFLAGS    = --binary --timing --assert -Wno-fatal
TOP       = tb_icache
FLIST     = compile.f
OBJ_DIR   = obj_dir
LOG       = sim.log

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FLIST)
	./$(OBJ_DIR)/V$(TOP) | tee $(LOG)
	@if grep -q "Test FAILED" $(LOG); then echo "Simulation failed"; exit 1; fi
	@if ! grep -q "Test OK" $(LOG); then echo "Simulation did not complete"; exit 1; fi

clean:
	rm -rf $(OBJ_DIR) $(LOG)

// File: compile.f
hw/icache_pkg.sv
hw/axi_pkg.sv
hw/icache_ctrl.sv
hw/icache_tag_array.sv
hw/icache_data_array.sv
hw/icache_refill.sv
hw/icache_top.sv
sim/tb_axi_mem.sv
sim/tb_icache.sv

// File: hw/axi_pkg.sv
//////////////////////////////////////////////////////////////////////
// AXI4 read channel encodings for the refill master
// Only INCR bursts are issued, and only instruction accesses
//////////////////////////////////////////////////////////////////////
`default_nettype none

package axi_pkg;

   localparam int AXI_DW      = 64;
   localparam int AXI_P_BYTES = $clog2(AXI_DW / 8);  // ARSIZE of a full beat

   localparam logic [1:0] AXI_BURST_INCR = 2'b01;

   // Unprivileged, secure, instruction
   localparam logic [2:0] AXI_PROT_INSN = 3'b100;

   // Normal non-cacheable non-bufferable
   localparam logic [3:0] AXI_CACHE_NONCACHEABLE = 4'b0010;

endpackage

`default_nettype wire

// File: hw/icache_ctrl.sv
//////////////////////////////////////////////////////////////////////
// Cache controller with boot walk, miss handling and replay
// The core must hold fetch_vld_i and fetch_addr_i while stall_o is high
// Stage 1 holds the accepted address, stage 2 the one under compare
//////////////////////////////////////////////////////////////////////
`default_nettype none

module icache_ctrl
#(
   parameter int AW     = 32,
   parameter int P_LINE = 5,
   parameter int P_SETS = 6
)
(
   input  wire            clk,
   input  wire            arst_n_i,
   input  wire            fetch_vld_i,
   input  wire [AW-1:0]   fetch_addr_i,
   input  wire            hit_i,
   input  wire            refill_done_i,
   output logic           stall_o,
   output logic           rd_en_o,
   output logic [AW-1:0]  rd_addr_o,
   output logic [AW-1:0]  s2_addr_o,
   output logic           s2_vld_o,
   output logic           tag_we_o,
   output logic           tag_clear_o,
   output logic           refill_start_o
);

   icache_pkg::icache_state_e state_q;
   icache_pkg::icache_state_e state_d;

   logic [P_SETS-1:0] boot_idx_q;
   logic [AW-1:0]     s1_addr_q;
   logic              s1_vld_q;
   logic              lookup;
   logic              miss;
   logic              advance;

   // REPLAY2 compares on the RAM data read in REPLAY1
   assign lookup  = (state_q == icache_pkg::S_IDLE) || (state_q == icache_pkg::S_REPLAY2);
   assign miss    = lookup && s2_vld_o && !hit_i;
   assign stall_o = !lookup || miss;
   assign advance = !stall_o;

   always_comb
   begin
      state_d = state_q;
      case (state_q)
         icache_pkg::S_BOOT:
            if (&boot_idx_q)
               state_d = icache_pkg::S_IDLE;
         icache_pkg::S_IDLE:
            if (miss)
               state_d = icache_pkg::S_REPLACE;
         icache_pkg::S_REPLACE:
            state_d = icache_pkg::S_REFILL;
         icache_pkg::S_REFILL:
            if (refill_done_i)
               state_d = icache_pkg::S_REPLAY1;
         icache_pkg::S_REPLAY1:
            state_d = icache_pkg::S_REPLAY2;
         default:
            state_d = icache_pkg::S_IDLE;
      endcase
   end

   always_ff @(posedge clk or negedge arst_n_i)
   begin
      if (!arst_n_i)
      begin
         state_q    <= icache_pkg::S_BOOT;
         boot_idx_q <= '0;
         s1_vld_q   <= 1'b0;
         s2_vld_o   <= 1'b0;
      end
      else
      begin
         state_q <= state_d;
         if (state_q == icache_pkg::S_BOOT)
            boot_idx_q <= boot_idx_q + 1'b1;
         if (advance)
         begin
            s1_vld_q <= fetch_vld_i;
            s2_vld_o <= s1_vld_q;
         end
      end
   end

   // Addresses are held frozen during a stall
   always_ff @(posedge clk)
   begin
      if (advance)
      begin
         s1_addr_q <= fetch_addr_i;
         s2_addr_o <= s1_addr_q;
      end
   end

   // RAM read address steering
   always_comb
   begin
      case (state_q)
         icache_pkg::S_BOOT:
            rd_addr_o = {{(AW-P_SETS-P_LINE){1'b0}}, boot_idx_q, {P_LINE{1'b0}}};
         icache_pkg::S_REPLAY1:
            rd_addr_o = s2_addr_o;
         default:
            rd_addr_o = s1_addr_q;   // Also the replay of stage 1 in REPLAY2
      endcase
   end

   assign rd_en_o        = advance || (state_q == icache_pkg::S_REPLAY1);
   assign tag_we_o       = (state_q == icache_pkg::S_BOOT) || (state_q == icache_pkg::S_REPLACE);
   assign tag_clear_o    = (state_q == icache_pkg::S_BOOT);
   assign refill_start_o = (state_q == icache_pkg::S_REPLACE);

   // Tag writes only while frozen and never together with a lookup read
   a_tag_we_frozen: assert property (@(posedge clk) disable iff (!arst_n_i)
      tag_we_o |-> (stall_o && !rd_en_o));

   a_start_pulse: assert property (@(posedge clk) disable iff (!arst_n_i)
      refill_start_o |-> ($past(miss) && !$past(refill_start_o)));

endmodule

`default_nettype wire

// File: hw/icache_data_array.sv
//////////////////////////////////////////////////////////////////////
// Payload RAMs, one fetch window wide per way
// The output register loads on every read enable
//////////////////////////////////////////////////////////////////////
`default_nettype none

module icache_data_array
#(
   parameter int AW     = 32,
   parameter int P_LINE = 5,
   parameter int P_SETS = 6,
   parameter int P_WAYS = 1
)
(
   input  wire                             clk,
   input  wire                             rd_en_i,
   input  wire  [AW-1:0]                   rd_addr_i,
   input  wire  [P_WAYS-1:0]               hit_way_i,
   input  wire  [P_WAYS-1:0]               wr_way_i,
   input  wire  [P_SETS+P_LINE-icache_pkg::P_FETCH_BYTES-1:0] wr_addr_i,
   input  wire  [icache_pkg::FETCH_DW/8-1:0] wr_be_i,
   input  wire  [icache_pkg::FETCH_DW-1:0] wr_data_i,
   output logic [icache_pkg::FETCH_DW-1:0] insn_o
);

   localparam int WAYS  = 1 << P_WAYS;
   localparam int DW    = icache_pkg::FETCH_DW;
   localparam int PAW   = P_SETS + P_LINE - icache_pkg::P_FETCH_BYTES;
   localparam int DEPTH = 1 << PAW;

   logic [DW-1:0] mem    [WAYS][DEPTH];
   logic [DW-1:0] rd_q   [WAYS];
   logic [PAW-1:0] rd_idx;

   assign rd_idx = rd_addr_i[icache_pkg::P_FETCH_BYTES +: PAW];   // {set, window}

   for (genvar w = 0; w < WAYS; w++)
   begin : g_way
      always_ff @(posedge clk)
      begin
         if (wr_way_i == P_WAYS'(w))
         begin
            for (int b = 0; b < DW / 8; b++)
            begin
               if (wr_be_i[b])
                  mem[w][wr_addr_i][b*8 +: 8] <= wr_data_i[b*8 +: 8];
            end
         end
         if (rd_en_i)
            rd_q[w] <= mem[w][rd_idx];
      end
   end

   // Hit way of the previous read
   always_ff @(posedge clk)
   begin
      if (rd_en_i)
         insn_o <= rd_q[hit_way_i];
   end

endmodule

`default_nettype wire

// File: hw/icache_pkg.sv
//////////////////////////////////////////////////////////////////////
// Instruction cache wide definitions
// The fetch window is a power of two instructions, two by default
// FSM states are shared with the testbench for its messages
//////////////////////////////////////////////////////////////////////
`default_nettype none

package icache_pkg;

   // Instruction and fetch window geometry
   localparam int INSN_DW       = 32;
   localparam int P_FETCH_WIDTH = 1;   // log2 of insns per window
   localparam int FETCH_DW      = INSN_DW << P_FETCH_WIDTH;
   localparam int P_FETCH_BYTES = $clog2(FETCH_DW / 8);

   // Main FSM of the cache controller
   typedef enum logic [2:0] {
      S_BOOT,     // Invalidate walk after reset
      S_IDLE,
      S_REPLACE,  // Victim tag write, burst start
      S_REFILL,
      S_REPLAY1,  // Re-read the missed address
      S_REPLAY2   // Re-read the following address
   } icache_state_e;

endpackage

`default_nettype wire

// File: hw/icache_refill.sv
//////////////////////////////////////////////////////////////////////
// AXI4 read master that fetches one cache line per start
// Beat width must not exceed the fetch window
// R response and last are not checked
//////////////////////////////////////////////////////////////////////
`default_nettype none

module icache_refill
#(
   parameter int AW     = 32,
   parameter int P_LINE = 5,
   parameter int P_SETS = 6
)
(
   input  wire             clk,
   input  wire             arst_n_i,
   input  wire             start_i,
   input  wire  [AW-1:0]   line_addr_i,
   output logic            arvalid_o,
   input  wire             arready_i,
   output logic [AW-1:0]   araddr_o,
   output logic [7:0]      arlen_o,
   output logic [2:0]      arsize_o,
   output logic [1:0]      arburst_o,
   output logic [2:0]      arprot_o,
   output logic [3:0]      arcache_o,
   input  wire             rvalid_i,
   output logic            rready_o,
   input  wire  [axi_pkg::AXI_DW-1:0] rdata_i,
   output logic [P_SETS+P_LINE-icache_pkg::P_FETCH_BYTES-1:0] wr_addr_o,
   output logic [icache_pkg::FETCH_DW/8-1:0] wr_be_o,
   output logic [icache_pkg::FETCH_DW-1:0]   wr_data_o,
   output logic            done_o
);

   localparam int AXI_B   = axi_pkg::AXI_DW / 8;
   localparam int LANES   = icache_pkg::FETCH_DW / axi_pkg::AXI_DW;   // beats per window
   localparam int BEAT_W  = P_LINE - axi_pkg::AXI_P_BYTES;
   localparam int SLOT_W  = P_LINE - icache_pkg::P_FETCH_BYTES;
   localparam int WB      = icache_pkg::FETCH_DW / 8;

   logic [AW-P_LINE-1:0] line_q;
   logic [BEAT_W-1:0]    beat_q;
   logic                 busy_q;
   logic                 hds_r;
   logic                 last_beat;
   logic [SLOT_W-1:0]    slot;
   int                   lane;

   assign hds_r     = rvalid_i && rready_o;
   assign last_beat = &beat_q;
   assign rready_o  = busy_q && !arvalid_o;   // Beats only after the AR handshake

   always_ff @(posedge clk or negedge arst_n_i)
   begin
      if (!arst_n_i)
      begin
         arvalid_o <= 1'b0;
         busy_q    <= 1'b0;
         beat_q    <= '0;
         done_o    <= 1'b0;
      end
      else
      begin
         done_o <= hds_r && last_beat;
         if (start_i)
         begin
            arvalid_o <= 1'b1;
            busy_q    <= 1'b1;
            beat_q    <= '0;
         end
         else if (arvalid_o && arready_i)
            arvalid_o <= 1'b0;
         if (hds_r)
         begin
            beat_q <= beat_q + 1'b1;
            if (last_beat)
               busy_q <= 1'b0;
         end
      end
   end

   always_ff @(posedge clk)
   begin
      if (start_i)
         line_q <= line_addr_i[AW-1:P_LINE];
   end

   assign araddr_o  = {line_q, {P_LINE{1'b0}}};   // Always line aligned
   assign arlen_o   = 8'((1 << BEAT_W) - 1);
   assign arsize_o  = 3'(axi_pkg::AXI_P_BYTES);
   assign arburst_o = axi_pkg::AXI_BURST_INCR;
   assign arprot_o  = axi_pkg::AXI_PROT_INSN;
   assign arcache_o = axi_pkg::AXI_CACHE_NONCACHEABLE;

   // Beat to window slot and byte lanes
   assign slot      = SLOT_W'(beat_q / LANES);
   assign lane      = int'(beat_q) % LANES;
   assign wr_addr_o = {line_q[P_SETS-1:0], slot};
   assign wr_be_o   = hds_r ? (WB'({AXI_B{1'b1}}) << (lane * AXI_B)) : '0;
   assign wr_data_o = {LANES{rdata_i}};

   a_ar_hold: assert property (@(posedge clk) disable iff (!arst_n_i)
      (arvalid_o && !arready_i) |=> (arvalid_o && $stable(araddr_o)));

endmodule

`default_nettype wire

// File: hw/icache_tag_array.sv
//////////////////////////////////////////////////////////////////////
// Tag and valid RAMs, one per way, with hit compare
// Victim choice is round-robin per set
// A write without clear_i stores the stage 2 tag into the victim way
//////////////////////////////////////////////////////////////////////
`default_nettype none

module icache_tag_array
#(
   parameter int AW     = 32,
   parameter int P_LINE = 5,
   parameter int P_SETS = 6,
   parameter int P_WAYS = 1
)
(
   input  wire               clk,
   input  wire               arst_n_i,
   input  wire               rd_en_i,
   input  wire  [AW-1:0]     rd_addr_i,
   input  wire  [AW-1:0]     s2_addr_i,
   input  wire               we_i,
   input  wire               clear_i,
   output logic              hit_o,
   output logic [P_WAYS-1:0] hit_way_o,
   output logic [P_WAYS-1:0] victim_way_o
);

   localparam int WAYS  = 1 << P_WAYS;
   localparam int SETS  = 1 << P_SETS;
   localparam int TAG_W = AW - P_SETS - P_LINE;

   logic [TAG_W:0]      tag_mem [WAYS][SETS];   // {tag, valid}
   logic [TAG_W:0]      tag_q   [WAYS];
   logic [P_WAYS-1:0]   rr_q    [SETS];
   logic [WAYS-1:0]     hit_vec;
   logic [P_SETS-1:0]   wr_idx;
   logic [P_WAYS-1:0]   victim_sel;
   logic [TAG_W-1:0]    s2_tag;

   assign s2_tag     = s2_addr_i[AW-1 -: TAG_W];
   assign wr_idx     = clear_i ? rd_addr_i[P_LINE +: P_SETS] : s2_addr_i[P_LINE +: P_SETS];
   assign victim_sel = rr_q[wr_idx];

   for (genvar w = 0; w < WAYS; w++)
   begin : g_way
      always_ff @(posedge clk)
      begin
         if (we_i && (clear_i || (victim_sel == P_WAYS'(w))))
            tag_mem[w][wr_idx] <= clear_i ? '0 : {s2_tag, 1'b1};
      end

      // Cleared so nothing hits before the first lookup
      always_ff @(posedge clk or negedge arst_n_i)
      begin
         if (!arst_n_i)
            tag_q[w] <= '0;
         else if (rd_en_i)
            tag_q[w] <= tag_mem[w][rd_addr_i[P_LINE +: P_SETS]];
      end

      assign hit_vec[w] = tag_q[w][0] && (tag_q[w][TAG_W:1] == s2_tag);
   end

   always_comb
   begin
      hit_way_o = '0;
      for (int w = WAYS - 1; w >= 0; w--)
      begin
         if (hit_vec[w])
            hit_way_o = P_WAYS'(w);   // Lowest way wins
      end
   end

   assign hit_o = |hit_vec;

   always_ff @(posedge clk or negedge arst_n_i)
   begin
      if (!arst_n_i)
      begin
         for (int s = 0; s < SETS; s++)
            rr_q[s] <= '0;
         victim_way_o <= '0;
      end
      else if (we_i && !clear_i)
      begin
         rr_q[wr_idx] <= victim_sel + 1'b1;
         victim_way_o <= victim_sel;   // Held for the refill writes
      end
   end

   a_one_hit: assert property (@(posedge clk) disable iff (!arst_n_i) $onehot0(hit_vec));

endmodule

`default_nettype wire

// File: hw/icache_top.sv
//////////////////////////////////////////////////////////////////////
// Two-way set-associative instruction cache, AXI4 read refill
// Physical addresses only, no flush besides the walk after reset
// Hits return a two-instruction window two cycles after acceptance
//////////////////////////////////////////////////////////////////////
`default_nettype none

module icache_top
#(
   parameter int AW     = 32,
   parameter int P_LINE = 5,
   parameter int P_SETS = 6,
   parameter int P_WAYS = 1
)
(
   input  wire            clk,
   input  wire            arst_n_i,
   input  wire            fetch_vld_i,
   input  wire  [AW-1:0]  fetch_addr_i,
   output logic           stall_o,
   output logic [icache_pkg::FETCH_DW-1:0] insn_o,
   output logic           insn_vld_o,
   output logic           arvalid_o,
   input  wire            arready_i,
   output logic [AW-1:0]  araddr_o,
   output logic [7:0]     arlen_o,
   output logic [2:0]     arsize_o,
   output logic [1:0]     arburst_o,
   output logic [2:0]     arprot_o,
   output logic [3:0]     arcache_o,
   input  wire            rvalid_i,
   output logic           rready_o,
   input  wire  [axi_pkg::AXI_DW-1:0] rdata_i
);

   localparam int PAW = P_SETS + P_LINE - icache_pkg::P_FETCH_BYTES;

   logic              rd_en, s2_vld, hit, tag_we, tag_clear;
   logic              refill_start, refill_done;
   logic [AW-1:0]     rd_addr, s2_addr;
   logic [P_WAYS-1:0] hit_way, victim_way;
   logic [PAW-1:0]    wr_addr;
   logic [icache_pkg::FETCH_DW/8-1:0] wr_be;
   logic [icache_pkg::FETCH_DW-1:0]   wr_data;

   icache_ctrl #(.AW(AW), .P_LINE(P_LINE), .P_SETS(P_SETS)) u_ctrl (
      .clk(clk), .arst_n_i(arst_n_i), .fetch_vld_i(fetch_vld_i), .fetch_addr_i(fetch_addr_i),
      .hit_i(hit), .refill_done_i(refill_done), .stall_o(stall_o), .rd_en_o(rd_en),
      .rd_addr_o(rd_addr), .s2_addr_o(s2_addr), .s2_vld_o(s2_vld), .tag_we_o(tag_we),
      .tag_clear_o(tag_clear), .refill_start_o(refill_start));

   icache_tag_array #(.AW(AW), .P_LINE(P_LINE), .P_SETS(P_SETS), .P_WAYS(P_WAYS)) u_tag (
      .clk(clk), .arst_n_i(arst_n_i), .rd_en_i(rd_en), .rd_addr_i(rd_addr),
      .s2_addr_i(s2_addr), .we_i(tag_we), .clear_i(tag_clear), .hit_o(hit),
      .hit_way_o(hit_way), .victim_way_o(victim_way));

   icache_data_array #(.AW(AW), .P_LINE(P_LINE), .P_SETS(P_SETS), .P_WAYS(P_WAYS)) u_data (
      .clk(clk), .rd_en_i(rd_en), .rd_addr_i(rd_addr), .hit_way_i(hit_way),
      .wr_way_i(victim_way), .wr_addr_i(wr_addr), .wr_be_i(wr_be), .wr_data_i(wr_data),
      .insn_o(insn_o));

   icache_refill #(.AW(AW), .P_LINE(P_LINE), .P_SETS(P_SETS)) u_refill (
      .clk(clk), .arst_n_i(arst_n_i), .start_i(refill_start), .line_addr_i(s2_addr),
      .arvalid_o(arvalid_o), .arready_i(arready_i), .araddr_o(araddr_o), .arlen_o(arlen_o),
      .arsize_o(arsize_o), .arburst_o(arburst_o), .arprot_o(arprot_o), .arcache_o(arcache_o),
      .rvalid_i(rvalid_i), .rready_o(rready_o), .rdata_i(rdata_i), .wr_addr_o(wr_addr),
      .wr_be_o(wr_be), .wr_data_o(wr_data), .done_o(refill_done));

   // Valid follows the output register, which loads as stage 2 leaves
   always_ff @(posedge clk or negedge arst_n_i)
   begin
      if (!arst_n_i)
         insn_vld_o <= 1'b0;
      else
         insn_vld_o <= s2_vld && !stall_o;
   end

endmodule

`default_nettype wire

// File: sim/tb_axi_mem.sv
//////////////////////////////////////////////////////////////////////
// AXI4 read slave model, one burst outstanding, INCR only
// Data is a pure function of the address, nothing is stored
// Assumes 64-bit beats holding two 32-bit words, low word first
// ARREADY and RVALID gap at random
//////////////////////////////////////////////////////////////////////
`default_nettype none

module tb_axi_mem
(
   input  wire                         clk,
   input  wire                         arst_n_i,
   input  wire                         arvalid_i,
   output logic                        arready_o,
   input  wire  [31:0]                 araddr_i,
   input  wire  [7:0]                  arlen_i,
   output logic                        rvalid_o,
   input  wire                         rready_i,
   output logic [axi_pkg::AXI_DW-1:0]  rdata_o
);

   localparam int BEAT_B = axi_pkg::AXI_DW / 8;

   logic        busy_q;
   logic [31:0] addr_q;    // Address of the current beat
   logic [7:0]  left_q;    // Beats after the current one

   function automatic logic [63:0] beat_data(input logic [31:0] addr);
      logic [29:0] wa;
      wa = addr[31:2];
      return {(32'(wa + 30'd1) * 32'h9e37_79b9) ^ 32'h5bd1_e995,
              (32'(wa) * 32'h9e37_79b9) ^ 32'h5bd1_e995};
   endfunction

   always @(posedge clk or negedge arst_n_i)
   begin
      if (!arst_n_i)
      begin
         arready_o <= 1'b0;
         rvalid_o  <= 1'b0;
         busy_q    <= 1'b0;
         addr_q    <= '0;
         left_q    <= '0;
      end
      else if (!busy_q)
      begin
         if (arvalid_i && arready_o)
         begin
            busy_q    <= 1'b1;
            addr_q    <= araddr_i;
            left_q    <= arlen_i;
            arready_o <= 1'b0;
         end
         else
            arready_o <= ($urandom_range(3, 0) != 0);
      end
      else if (rvalid_o && rready_i)
      begin
         addr_q <= addr_q + 32'(BEAT_B);
         left_q <= left_q - 8'd1;
         if (left_q == 8'd0)
         begin
            busy_q   <= 1'b0;   // Burst complete
            rvalid_o <= 1'b0;
         end
         else
            rvalid_o <= ($urandom_range(3, 0) != 0);
      end
      else if (!rvalid_o)
         rvalid_o <= ($urandom_range(3, 0) != 0);   // Held once raised
   end

   assign rdata_o = beat_data(addr_q);

endmodule

`default_nettype wire

// File: sim/tb_icache.sv
//////////////////////////////////////////////////////////////////////
// Testbench for the instruction cache with an AXI memory model
// Results are checked in request order against a reference window
// Expected bursts come from a per-set residency model
//////////////////////////////////////////////////////////////////////
`default_nettype none

module tb_icache;

   localparam int AW         = 32;
   localparam int P_LINE     = 5;
   localparam int P_SETS     = 6;
   localparam int P_WAYS     = 1;
   localparam int WAYS       = 1 << P_WAYS;
   localparam int SETS       = 1 << P_SETS;
   localparam int TAG_W      = AW - P_SETS - P_LINE;
   localparam int SET_STRIDE = 1 << (P_LINE + P_SETS);
   localparam int CLK_PER    = 8;
   localparam int RST_CYC    = 16;
   localparam int N_RAND     = 200;
   localparam int N_REQ      = 1 + 8 + 4 + N_RAND;
   localparam int REFILL_MAX = 64;   // Worst case per request with AXI gaps
   localparam int WD_CYC     = RST_CYC + SETS + N_REQ * REFILL_MAX;

   logic                            clk;
   logic                            arst_n_i;
   logic                            fetch_vld_i;
   logic [AW-1:0]                   fetch_addr_i;
   logic                            stall_o;
   logic [icache_pkg::FETCH_DW-1:0] insn_o;
   logic                            insn_vld_o;
   logic                            arvalid_o;
   logic                            arready_i;
   logic [AW-1:0]                   araddr_o;
   logic [7:0]                      arlen_o;
   logic [2:0]                      arsize_o;
   logic [1:0]                      arburst_o;
   logic [2:0]                      arprot_o;
   logic [3:0]                      arcache_o;
   logic                            rvalid_i;
   logic                            rready_o;
   logic [axi_pkg::AXI_DW-1:0]      rdata_i;

   logic [AW-1:0]    exp_q [$];    // Accepted addresses in order of arrival
   logic [AW-1:0]    line_q [$];   // Predicted burst addresses
   logic [TAG_W-1:0] res_tag [SETS][WAYS];
   logic             res_vld [SETS][WAYS];
   int unsigned      res_rr [SETS];
   int               errors;
   int               results;
   int               bursts;
   int               predicted;
   int               boot_cycles;
   int               b0;
   icache_pkg::icache_state_e state_seen;

   assign state_seen = uut.u_ctrl.state_q;

   icache_top #(.AW(AW), .P_LINE(P_LINE), .P_SETS(P_SETS), .P_WAYS(P_WAYS)) uut (
      .clk(clk), .arst_n_i(arst_n_i), .fetch_vld_i(fetch_vld_i), .fetch_addr_i(fetch_addr_i),
      .stall_o(stall_o), .insn_o(insn_o), .insn_vld_o(insn_vld_o), .arvalid_o(arvalid_o),
      .arready_i(arready_i), .araddr_o(araddr_o), .arlen_o(arlen_o), .arsize_o(arsize_o),
      .arburst_o(arburst_o), .arprot_o(arprot_o), .arcache_o(arcache_o),
      .rvalid_i(rvalid_i), .rready_o(rready_o), .rdata_i(rdata_i));

   tb_axi_mem u_mem (
      .clk(clk), .arst_n_i(arst_n_i), .arvalid_i(arvalid_o), .arready_o(arready_i),
      .araddr_i(araddr_o), .arlen_i(arlen_o), .rvalid_o(rvalid_i), .rready_i(rready_o),
      .rdata_o(rdata_i));

   // Each instruction word is a fixed mix of its word address
   function automatic logic [31:0] insn_ref(input logic [29:0] wa);
      return (32'(wa) * 32'h9e37_79b9) ^ 32'h5bd1_e995;
   endfunction

   function automatic logic [63:0] window_ref(input logic [AW-1:0] addr);
      logic [29:0] wa;
      wa = {addr[31:3], 1'b0};
      return {insn_ref(wa + 30'd1), insn_ref(wa)};   // Lower address in low half
   endfunction

   task automatic check_value(input string what, input logic [63:0] got,
                              input logic [63:0] exp);
      assert (got == exp) else
      begin
         errors++;
         $display("Error at %0t: %s is %0h, expected %0h", $time, what, got, exp);
      end
   endtask

   // Misses fill the round-robin victim of the set and hits leave it alone
   task automatic track_residency(input logic [AW-1:0] addr);
      int               set;
      logic [TAG_W-1:0] tag;
      logic             hit;
      set = int'(addr[P_LINE +: P_SETS]);
      tag = addr[AW-1 -: TAG_W];
      hit = 1'b0;
      for (int w = 0; w < WAYS; w++)
         if (res_vld[set][w] && (res_tag[set][w] == tag))
            hit = 1'b1;
      if (!hit)
      begin
         res_vld[set][res_rr[set]] = 1'b1;
         res_tag[set][res_rr[set]] = tag;
         res_rr[set] = (res_rr[set] + 1) % WAYS;
         line_q.push_back({addr[AW-1:P_LINE], {P_LINE{1'b0}}});
         predicted++;
      end
   endtask

   task automatic send(input logic [AW-1:0] addr);
      fetch_vld_i  <= 1'b1;
      fetch_addr_i <= addr;
      @(negedge clk);
      while (stall_o)
         @(negedge clk);   // Held until accepted
      @(posedge clk);
      exp_q.push_back(addr);
      track_residency(addr);
   endtask

   task automatic bubble();
      fetch_vld_i <= 1'b0;
      @(posedge clk);
   endtask

   task automatic drain();
      fetch_vld_i <= 1'b0;
      while (exp_q.size() != 0)
         @(posedge clk);
      @(posedge clk);
   endtask

   task automatic print_summary();
      $display("Results %0d of %0d, bursts %0d of %0d predicted, errors %0d",
               results, N_REQ, bursts, predicted, errors);
   endtask

   initial
   begin
      clk = 1'b0;
      forever #(CLK_PER / 2) clk = ~clk;
   end

   // Compare each result with the oldest request
   always @(negedge clk)
   begin
      if (arst_n_i && insn_vld_o)
      begin
         results++;
         if (exp_q.size() == 0)
         begin
            errors++;
            $display("Result at %0t arrived with no request outstanding", $time);
         end
         else
            check_value("fetch window", insn_o, window_ref(exp_q.pop_front()));
      end
   end

   // AR handshake lands on the next rising edge
   always @(negedge clk)
   begin
      if (arst_n_i && arvalid_o && arready_i)
      begin
         bursts++;
         check_value("araddr offset", araddr_o[P_LINE-1:0], 0);
         check_value("arlen", arlen_o, (1 << P_LINE) / (axi_pkg::AXI_DW / 8) - 1);
         check_value("arsize in bytes", 64'd1 << arsize_o, axi_pkg::AXI_DW / 8);
         check_value("arburst", arburst_o, axi_pkg::AXI_BURST_INCR);
         check_value("arprot", arprot_o, axi_pkg::AXI_PROT_INSN);
         check_value("arcache", arcache_o, axi_pkg::AXI_CACHE_NONCACHEABLE);
         if (line_q.size() == 0)
         begin
            errors++;
            $display("Burst to %h at %0t was not expected by the residency model",
                     araddr_o, $time);
         end
         else
            check_value("araddr", araddr_o, line_q.pop_front());
      end
   end

   initial
   begin
      #(WD_CYC * CLK_PER);
      $display("Watchdog expired in state %s with %0d requests outstanding",
               state_seen.name(), exp_q.size());
      print_summary();
      $display("Test FAILED");
      $finish;
   end

   initial
   begin
      void'($urandom(32'hd39d_c4d8));
      errors       = 0;
      results      = 0;
      bursts       = 0;
      predicted    = 0;
      boot_cycles  = 0;
      arst_n_i     = 1'b0;
      fetch_vld_i  = 1'b0;
      fetch_addr_i = '0;
      for (int s = 0; s < SETS; s++)
      begin
         res_rr[s] = 0;
         for (int w = 0; w < WAYS; w++)
         begin
            res_vld[s][w] = 1'b0;
            res_tag[s][w] = '0;
         end
      end
      repeat (RST_CYC) @(posedge clk);
      check_value("stall_o in reset", stall_o, 1);
      check_value("arvalid_o in reset", arvalid_o, 0);
      check_value("rready_o in reset", rready_o, 0);
      check_value("insn_vld_o in reset", insn_vld_o, 0);
      arst_n_i <= 1'b1;

      // Boot walk over every set
      @(negedge clk);
      while (stall_o)
      begin
         boot_cycles++;
         @(negedge clk);
      end
      @(posedge clk);
      check_value("boot walk cycles", boot_cycles, SETS);
      check_value("bursts before first request", bursts, 0);

      b0 = bursts;
      send(32'h0000_1004);
      drain();
      check_value("bursts of a cold miss", bursts - b0, 1);

      // Back to back over the resident line
      b0 = bursts;
      for (int i = 0; i < 8; i++)
         send(32'h0000_1000 + 32'(i * 4));
      drain();
      check_value("bursts on a resident line", bursts - b0, 0);

      // Third line in set 2 evicts the first
      b0 = bursts;
      for (int i = 0; i < 3; i++)
         send(32'h0004_0040 + 32'(i * SET_STRIDE));
      send(32'h0004_0040);
      drain();
      check_value("bursts within one set", bursts - b0, 4);

      for (int i = 0; i < N_RAND; i++)
      begin
         if ($urandom_range(3, 0) == 0)
            bubble();
         send(32'h0001_0000 + (32'($urandom_range(2047, 0)) << 2));
      end
      drain();

      check_value("results returned", results, N_REQ);
      check_value("bursts against the model", bursts, predicted);
      check_value("predicted bursts left over", line_q.size(), 0);
      print_summary();
      if (errors == 0)
         $display("Test OK");
      else
         $display("Test FAILED");
      $finish;
   end

endmodule

`default_nettype wire
